// File: logic/axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

    // data bus width of the host port
    localparam int AXIL_DATA_W = 32;

    // response code carried on bresp and rresp
    typedef logic [1:0] axil_resp_t;

    // only OKAY is ever returned
    localparam axil_resp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// File: logic/rx_regmap_pkg.sv
`default_nettype none

package rx_regmap_pkg;

    // word address is byte address bits 10:2
    localparam int REG_ADDR_W = 9;

    // largest legal physical cell identity
    localparam int N_ID_MAX = 1007;
    localparam int N_ID_W = $clog2(N_ID_MAX);

    // identification words
    localparam logic [31:0] PCORE_VERSION = 32'h0001_0061;
    // reads as ascii "RX~~"
    localparam logic [31:0] MAGIC_WORD = 32'h5258_7E7E;
    localparam logic [31:0] FILL_WORD = 32'h6969_6969;

    // word addresses of the register map
    localparam logic [REG_ADDR_W-1:0] ADDR_VERSION = 9'h000;
    localparam logic [REG_ADDR_W-1:0] ADDR_ID = 9'h001;
    localparam logic [REG_ADDR_W-1:0] ADDR_SCRATCH = 9'h002;
    localparam logic [REG_ADDR_W-1:0] ADDR_MAGIC = 9'h003;
    localparam logic [REG_ADDR_W-1:0] ADDR_FILL = 9'h004;
    localparam logic [REG_ADDR_W-1:0] ADDR_FS_STATE = 9'h005;
    localparam logic [REG_ADDR_W-1:0] ADDR_RX_SIGNAL = 9'h006;
    localparam logic [REG_ADDR_W-1:0] ADDR_N_ID_2 = 9'h007;
    localparam logic [REG_ADDR_W-1:0] ADDR_N_ID = 9'h008;
    localparam logic [REG_ADDR_W-1:0] ADDR_SAMPLE_MISMATCH = 9'h009;
    localparam logic [REG_ADDR_W-1:0] ADDR_MISSED_SSBS = 9'h00A;
    localparam logic [REG_ADDR_W-1:0] ADDR_IBAR_SSB = 9'h00B;
    localparam logic [REG_ADDR_W-1:0] ADDR_CLKS_BTWN_SSBS = 9'h00C;
    localparam logic [REG_ADDR_W-1:0] ADDR_NUM_DISCONNECTS = 9'h00D;
    localparam logic [REG_ADDR_W-1:0] ADDR_N_ID_USED = 9'h00E;

endpackage

`default_nettype wire

// File: logic/reg_bus_if.sv
`default_nettype none

interface reg_bus_if
    import axi_lite_pkg::*;
    import rx_regmap_pkg::*;
();

    // write request and its acknowledge
    logic                   wreq;
    logic [REG_ADDR_W-1:0]  waddr;
    logic [AXIL_DATA_W-1:0] wdata;
    logic                   wack;

    // read request, acknowledge and returned word
    logic                   rreq;
    logic [REG_ADDR_W-1:0]  raddr;
    logic [AXIL_DATA_W-1:0] rdata;
    logic                   rack;

    modport master (
        output wreq, waddr, wdata, rreq, raddr,
        input  wack, rdata, rack
    );

    modport slave (
        input  wreq, waddr, wdata, rreq, raddr,
        output wack, rdata, rack
    );

endinterface

`default_nettype wire

// File: logic/axi_lite_slave.sv
`default_nettype none

module axi_lite_slave
    import axi_lite_pkg::*;
    import rx_regmap_pkg::*;
#(
    parameter int ADDRESS_WIDTH = 11
) (
    input  wire                       clk_i,
    input  wire                       reset_ni,

    input  wire [ADDRESS_WIDTH-1:0]   s_axi_awaddr_i,
    input  wire                       s_axi_awvalid_i,
    output logic                      s_axi_awready_o,

    // byte strobes are accepted but every write stores the full word
    input  wire [AXIL_DATA_W-1:0]     s_axi_wdata_i,
    input  wire [AXIL_DATA_W/8-1:0]   s_axi_wstrb_i,
    input  wire                       s_axi_wvalid_i,
    output logic                      s_axi_wready_o,

    output axil_resp_t                s_axi_bresp_o,
    output logic                      s_axi_bvalid_o,
    input  wire                       s_axi_bready_i,

    input  wire [ADDRESS_WIDTH-1:0]   s_axi_araddr_i,
    input  wire                       s_axi_arvalid_i,
    output logic                      s_axi_arready_o,

    output logic [AXIL_DATA_W-1:0]    s_axi_rdata_o,
    output axil_resp_t                s_axi_rresp_o,
    output logic                      s_axi_rvalid_o,
    input  wire                       s_axi_rready_i,

    reg_bus_if.master                 reg_bus
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_RESP
    } xfer_state_t;

    xfer_state_t            w_state;
    xfer_state_t            r_state;
    logic                   aw_w_ready_q;
    logic                   ar_ready_q;
    logic [REG_ADDR_W-1:0]  waddr_q;
    logic [AXIL_DATA_W-1:0] wdata_q;
    logic [REG_ADDR_W-1:0]  raddr_q;
    logic [AXIL_DATA_W-1:0] rdata_q;

    // write side
    // ready is raised for one cycle once address and data are both present
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            w_state <= ST_IDLE;
            aw_w_ready_q <= 1'b0;
        end else begin
            case (w_state)
                ST_IDLE: begin
                    if (aw_w_ready_q) begin
                        aw_w_ready_q <= 1'b0;
                        w_state <= ST_REQ;
                    end else if (s_axi_awvalid_i && s_axi_wvalid_i) begin
                        aw_w_ready_q <= 1'b1;
                    end
                end
                ST_REQ: w_state <= ST_WAIT;
                ST_WAIT: begin
                    if (reg_bus.wack) begin
                        w_state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (s_axi_bready_i) begin
                        w_state <= ST_IDLE;
                    end
                end
                default: w_state <= ST_IDLE;
            endcase
        end
    end

    // address and data captured in the handshake cycle
    always_ff @(posedge clk_i) begin
        if (w_state == ST_IDLE && aw_w_ready_q) begin
            waddr_q <= s_axi_awaddr_i[REG_ADDR_W+1:2];
            wdata_q <= s_axi_wdata_i;
        end
    end

    // read side
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            r_state <= ST_IDLE;
            ar_ready_q <= 1'b0;
        end else begin
            case (r_state)
                ST_IDLE: begin
                    if (ar_ready_q) begin
                        ar_ready_q <= 1'b0;
                        r_state <= ST_REQ;
                    end else if (s_axi_arvalid_i) begin
                        ar_ready_q <= 1'b1;
                    end
                end
                ST_REQ: r_state <= ST_WAIT;
                ST_WAIT: begin
                    if (reg_bus.rack) begin
                        r_state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (s_axi_rready_i) begin
                        r_state <= ST_IDLE;
                    end
                end
                default: r_state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (r_state == ST_IDLE && ar_ready_q) begin
            raddr_q <= s_axi_araddr_i[REG_ADDR_W+1:2];
        end
        // read word held here for as long as rvalid waits on rready
        if (r_state == ST_WAIT && reg_bus.rack) begin
            rdata_q <= reg_bus.rdata;
        end
    end

    assign s_axi_awready_o = aw_w_ready_q;
    assign s_axi_wready_o = aw_w_ready_q;
    assign s_axi_bvalid_o = (w_state == ST_RESP);
    assign s_axi_bresp_o = RESP_OKAY;

    assign s_axi_arready_o = ar_ready_q;
    assign s_axi_rvalid_o = (r_state == ST_RESP);
    assign s_axi_rdata_o = rdata_q;
    assign s_axi_rresp_o = RESP_OKAY;

    assign reg_bus.wreq = (w_state == ST_REQ);
    assign reg_bus.waddr = waddr_q;
    assign reg_bus.wdata = wdata_q;
    assign reg_bus.rreq = (r_state == ST_REQ);
    assign reg_bus.raddr = raddr_q;

    a_bvalid_held : assert property (@(posedge clk_i) disable iff (!reset_ni)
        s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o);

    // the register map must answer exactly one cycle after the request
    a_wack_follows_wreq : assert property (@(posedge clk_i) disable iff (!reset_ni)
        reg_bus.wack |-> $past(reg_bus.wreq));

endmodule

`default_nettype wire

// File: logic/ssb_monitor.sv
`default_nettype none

module ssb_monitor #(
    parameter int SSB_TIMEOUT = 64
) (
    input  wire         clk_i,
    input  wire         reset_ni,
    input  wire         ssb_strobe_i,
    input  wire         sync_lost_i,
    output logic [31:0] clks_btwn_ssbs_o,
    output logic [15:0] missed_ssbs_o,
    output logic [31:0] num_disconnects_o
);

    // clocks since the last strobe, minus one
    logic [31:0] clk_cnt;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            clk_cnt <= '0;
            clks_btwn_ssbs_o <= '0;
            missed_ssbs_o <= '0;
        end else begin
            if (ssb_strobe_i) begin
                // spacing includes the strobe cycle itself
                clks_btwn_ssbs_o <= clk_cnt + 32'd1;
                clk_cnt <= '0;
            end else if (clk_cnt == 32'(SSB_TIMEOUT - 1)) begin
                // a full timeout period without a strobe is one missed block
                if (missed_ssbs_o != '1) begin
                    missed_ssbs_o <= missed_ssbs_o + 16'd1;
                end
                clk_cnt <= '0;
            end else begin
                clk_cnt <= clk_cnt + 32'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            num_disconnects_o <= '0;
        end else if (sync_lost_i && num_disconnects_o != '1) begin
            num_disconnects_o <= num_disconnects_o + 32'd1;
        end
    end

    // the receiver cannot deliver a block while it is losing sync
    a_strobe_excl_lost : assert property (@(posedge clk_i) disable iff (!reset_ni)
        !(ssb_strobe_i && sync_lost_i));

endmodule

`default_nettype wire

// File: logic/receiver_regmap.sv
`default_nettype none

module receiver_regmap
    import axi_lite_pkg::*;
    import rx_regmap_pkg::*;
#(
    parameter logic [AXIL_DATA_W-1:0] ID = '0
) (
    input  wire                 clk_i,
    input  wire                 reset_ni,
    reg_bus_if.slave            reg_bus,

    input  wire [1:0]           fs_state_i,
    input  wire [31:0]          rx_signal_i,
    input  wire [1:0]           n_id_2_i,
    input  wire [N_ID_W-1:0]    n_id_i,
    input  wire signed [7:0]    sample_cnt_mismatch_i,
    input  wire [15:0]          missed_ssbs_i,
    input  wire [2:0]           ibar_ssb_i,
    input  wire [31:0]          clks_btwn_ssbs_i,
    input  wire [31:0]          num_disconnects_i,
    input  wire [31:0]          n_id_used_i
);

    logic [AXIL_DATA_W-1:0] scratch_q;
    logic [AXIL_DATA_W-1:0] rd_word;

    // read decode
    // narrow fields land in the low bits, the rest stays zero
    always_comb begin
        rd_word = '0;
        case (reg_bus.raddr)
            ADDR_VERSION: rd_word = PCORE_VERSION;
            ADDR_ID: rd_word = ID;
            ADDR_SCRATCH: rd_word = scratch_q;
            ADDR_MAGIC: rd_word = MAGIC_WORD;
            ADDR_FILL: rd_word = FILL_WORD;
            ADDR_FS_STATE: rd_word[1:0] = fs_state_i;
            ADDR_RX_SIGNAL: rd_word = rx_signal_i;
            ADDR_N_ID_2: rd_word[1:0] = n_id_2_i;
            ADDR_N_ID: rd_word[N_ID_W-1:0] = n_id_i;
            // raw two's complement byte, no sign extension
            ADDR_SAMPLE_MISMATCH: rd_word[7:0] = sample_cnt_mismatch_i;
            ADDR_MISSED_SSBS: rd_word[15:0] = missed_ssbs_i;
            ADDR_IBAR_SSB: rd_word[2:0] = ibar_ssb_i;
            ADDR_CLKS_BTWN_SSBS: rd_word = clks_btwn_ssbs_i;
            ADDR_NUM_DISCONNECTS: rd_word = num_disconnects_i;
            ADDR_N_ID_USED: rd_word = n_id_used_i;
            default: rd_word = '0;
        endcase
    end

    // acknowledges follow their request by one cycle
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            reg_bus.rack <= 1'b0;
            reg_bus.wack <= 1'b0;
        end else begin
            reg_bus.rack <= reg_bus.rreq;
            reg_bus.wack <= reg_bus.wreq;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reg_bus.rreq) begin
            reg_bus.rdata <= rd_word;
        end
    end

    // scratch is the only writable word
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            scratch_q <= '0;
        end else if (reg_bus.wreq && reg_bus.waddr == ADDR_SCRATCH) begin
            scratch_q <= reg_bus.wdata;
        end
    end

    a_n_id_range : assert property (@(posedge clk_i) disable iff (!reset_ni)
        n_id_i <= N_ID_W'(N_ID_MAX));

endmodule

`default_nettype wire

// File: logic/rx_status_top.sv
`default_nettype none

module rx_status_top
    import axi_lite_pkg::*;
    import rx_regmap_pkg::*;
#(
    parameter logic [AXIL_DATA_W-1:0] ID = '0,
    parameter int ADDRESS_WIDTH = 11,
    parameter int SSB_TIMEOUT = 64
) (
    input  wire                       clk_i,
    input  wire                       reset_ni,

    input  wire [ADDRESS_WIDTH-1:0]   s_axi_awaddr_i,
    input  wire                       s_axi_awvalid_i,
    output wire                       s_axi_awready_o,
    input  wire [AXIL_DATA_W-1:0]     s_axi_wdata_i,
    input  wire [AXIL_DATA_W/8-1:0]   s_axi_wstrb_i,
    input  wire                       s_axi_wvalid_i,
    output wire                       s_axi_wready_o,
    output axil_resp_t                s_axi_bresp_o,
    output wire                       s_axi_bvalid_o,
    input  wire                       s_axi_bready_i,
    input  wire [ADDRESS_WIDTH-1:0]   s_axi_araddr_i,
    input  wire                       s_axi_arvalid_i,
    output wire                       s_axi_arready_o,
    output wire [AXIL_DATA_W-1:0]     s_axi_rdata_o,
    output axil_resp_t                s_axi_rresp_o,
    output wire                       s_axi_rvalid_o,
    input  wire                       s_axi_rready_i,

    // strobes from the receiver
    input  wire                       ssb_strobe_i,
    input  wire                       sync_lost_i,

    // status values from the receiver
    input  wire [1:0]                 fs_state_i,
    input  wire [31:0]                rx_signal_i,
    input  wire [1:0]                 n_id_2_i,
    input  wire [N_ID_W-1:0]          n_id_i,
    input  wire signed [7:0]          sample_cnt_mismatch_i,
    input  wire [2:0]                 ibar_ssb_i,
    input  wire [31:0]                n_id_used_i
);

    wire [31:0] clks_btwn_ssbs;
    wire [15:0] missed_ssbs;
    wire [31:0] num_disconnects;

    reg_bus_if reg_bus ();

    axi_lite_slave #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH)
    ) axi_lite_slave_inst (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .s_axi_awaddr_i(s_axi_awaddr_i),
        .s_axi_awvalid_i(s_axi_awvalid_i),
        .s_axi_awready_o(s_axi_awready_o),
        .s_axi_wdata_i(s_axi_wdata_i),
        .s_axi_wstrb_i(s_axi_wstrb_i),
        .s_axi_wvalid_i(s_axi_wvalid_i),
        .s_axi_wready_o(s_axi_wready_o),
        .s_axi_bresp_o(s_axi_bresp_o),
        .s_axi_bvalid_o(s_axi_bvalid_o),
        .s_axi_bready_i(s_axi_bready_i),
        .s_axi_araddr_i(s_axi_araddr_i),
        .s_axi_arvalid_i(s_axi_arvalid_i),
        .s_axi_arready_o(s_axi_arready_o),
        .s_axi_rdata_o(s_axi_rdata_o),
        .s_axi_rresp_o(s_axi_rresp_o),
        .s_axi_rvalid_o(s_axi_rvalid_o),
        .s_axi_rready_i(s_axi_rready_i),
        .reg_bus(reg_bus.master)
    );

    ssb_monitor #(
        .SSB_TIMEOUT(SSB_TIMEOUT)
    ) ssb_monitor_inst (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .ssb_strobe_i(ssb_strobe_i),
        .sync_lost_i(sync_lost_i),
        .clks_btwn_ssbs_o(clks_btwn_ssbs),
        .missed_ssbs_o(missed_ssbs),
        .num_disconnects_o(num_disconnects)
    );

    receiver_regmap #(
        .ID(ID)
    ) receiver_regmap_inst (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .reg_bus(reg_bus.slave),
        .fs_state_i(fs_state_i),
        .rx_signal_i(rx_signal_i),
        .n_id_2_i(n_id_2_i),
        .n_id_i(n_id_i),
        .sample_cnt_mismatch_i(sample_cnt_mismatch_i),
        .missed_ssbs_i(missed_ssbs),
        .ibar_ssb_i(ibar_ssb_i),
        .clks_btwn_ssbs_i(clks_btwn_ssbs),
        .num_disconnects_i(num_disconnects),
        .n_id_used_i(n_id_used_i)
    );

endmodule

`default_nettype wire

// File: bench/rx_status_tb.sv
`default_nettype none

module rx_status_tb
    import axi_lite_pkg::*;
    import rx_regmap_pkg::*;
();

    localparam logic [31:0] CORE_ID = 32'hA5C3_0017;
    localparam int TIMEOUT = 64;
    localparam int MAX_CYCLES = 4000;

    logic clk_i = 1'b0;
    logic reset_ni;
    logic [10:0] s_axi_awaddr_i, s_axi_araddr_i;
    logic s_axi_awvalid_i, s_axi_wvalid_i, s_axi_bready_i, s_axi_arvalid_i, s_axi_rready_i;
    logic [31:0] s_axi_wdata_i;
    logic [3:0] s_axi_wstrb_i;
    wire s_axi_awready_o, s_axi_wready_o, s_axi_bvalid_o, s_axi_arready_o, s_axi_rvalid_o;
    wire [1:0] s_axi_bresp_o, s_axi_rresp_o;
    wire [31:0] s_axi_rdata_o;
    logic ssb_strobe_i, sync_lost_i;
    logic [1:0] fs_state_i, n_id_2_i;
    logic [31:0] rx_signal_i, n_id_used_i;
    logic [N_ID_W-1:0] n_id_i;
    logic signed [7:0] sample_cnt_mismatch_i;
    logic [2:0] ibar_ssb_i;

    integer seed = 36335;
    int cycles = 0;
    logic [31:0] scratch_sh;
    logic [31:0] exp_q[$];
    logic [31:0] exp_word;
    // monitor model state
    logic [31:0] m_cnt, m_clks, m_disc;
    logic [15:0] m_missed;

    rx_status_top #(
        .ID(CORE_ID),
        .ADDRESS_WIDTH(11),
        .SSB_TIMEOUT(TIMEOUT)
    ) rx_status_top_inst (.*);

    always #5 clk_i = ~clk_i;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_on_error("run did not finish within the cycle limit");
        end
    end

    // spacing, missed blocks and disconnects as the receiver spec defines them
    always @(posedge clk_i) begin
        if (!reset_ni) begin
            m_cnt <= '0;
            m_clks <= '0;
            m_missed <= '0;
            m_disc <= '0;
        end else begin
            if (ssb_strobe_i) begin
                m_clks <= m_cnt + 32'd1;
                m_cnt <= '0;
            end else if (m_cnt == 32'(TIMEOUT - 1)) begin
                m_missed <= (m_missed == 16'hFFFF) ? m_missed : m_missed + 16'd1;
                m_cnt <= '0;
            end else begin
                m_cnt <= m_cnt + 32'd1;
            end
            if (sync_lost_i) begin
                m_disc <= m_disc + 32'd1;
            end
        end
    end

    function automatic logic [31:0] ref_read(input logic [8:0] a);
        logic [31:0] w;
        w = '0;
        case (a)
            ADDR_VERSION: w = PCORE_VERSION;
            ADDR_ID: w = CORE_ID;
            ADDR_SCRATCH: w = scratch_sh;
            ADDR_MAGIC: w = MAGIC_WORD;
            ADDR_FILL: w = FILL_WORD;
            ADDR_FS_STATE: w = {30'd0, fs_state_i};
            ADDR_RX_SIGNAL: w = rx_signal_i;
            ADDR_N_ID_2: w = {30'd0, n_id_2_i};
            ADDR_N_ID: w = {22'd0, n_id_i};
            ADDR_SAMPLE_MISMATCH: w = {24'd0, sample_cnt_mismatch_i};
            ADDR_MISSED_SSBS: w = {16'd0, m_missed};
            ADDR_IBAR_SSB: w = {29'd0, ibar_ssb_i};
            ADDR_CLKS_BTWN_SSBS: w = m_clks;
            ADDR_NUM_DISCONNECTS: w = m_disc;
            ADDR_N_ID_USED: w = n_id_used_i;
            default: w = '0;
        endcase
        return w;
    endfunction

    // compares every completed response against its queued expectation
    always @(posedge clk_i) begin
        if (s_axi_rvalid_o && s_axi_rready_i) begin
            assert (exp_q.size() > 0) else stop_on_error("read response with no pending read");
            exp_word = exp_q.pop_front();
            assert (s_axi_rdata_o == exp_word) else stop_on_error(
                $sformatf("Fail s_axi_rdata_o got %h expected %h", s_axi_rdata_o, exp_word));
            assert (s_axi_rresp_o == RESP_OKAY) else stop_on_error(
                $sformatf("Fail s_axi_rresp_o got %h expected %h", s_axi_rresp_o, RESP_OKAY));
        end
        if (s_axi_bvalid_o && s_axi_bready_i) begin
            assert (s_axi_bresp_o == RESP_OKAY) else stop_on_error(
                $sformatf("Fail s_axi_bresp_o got %h expected %h", s_axi_bresp_o, RESP_OKAY));
        end
    end

    task automatic axil_read(input logic [8:0] a, input int stall);
        int lat;
        logic [31:0] held;
        s_axi_araddr_i = {a, 2'b00};
        s_axi_arvalid_i = 1'b1;
        do begin
            @(posedge clk_i); #1;
        end while (!s_axi_arready_o);
        @(posedge clk_i); #1;
        s_axi_arvalid_i = 1'b0;
        lat = 1;
        // monitor model now matches what the map decodes in its request cycle
        exp_q.push_back(ref_read(a));
        while (!s_axi_rvalid_o) begin
            @(posedge clk_i); #1;
            lat++;
        end
        assert (lat == 3) else stop_on_error($sformatf("Fail read latency got %h expected %h",
            lat, 3));
        held = s_axi_rdata_o;
        repeat (stall) begin
            @(posedge clk_i); #1;
            assert (s_axi_rvalid_o && s_axi_rdata_o == held) else stop_on_error(
                $sformatf("Fail s_axi_rdata_o got %h expected %h", s_axi_rdata_o, held));
        end
        s_axi_rready_i = 1'b1;
        @(posedge clk_i); #1;
        s_axi_rready_i = 1'b0;
    endtask

    task automatic axil_write(input logic [8:0] a, input logic [31:0] d,
                              input logic [3:0] strb, input int stall);
        s_axi_awaddr_i = {a, 2'b00};
        s_axi_wdata_i = d;
        s_axi_wstrb_i = strb;
        s_axi_awvalid_i = 1'b1;
        s_axi_wvalid_i = 1'b1;
        do begin
            @(posedge clk_i); #1;
        end while (!s_axi_awready_o);
        // address and data are taken in the same cycle
        assert (s_axi_wready_o) else stop_on_error(
            $sformatf("Fail s_axi_wready_o got %h expected %h", s_axi_wready_o, 1'b1));
        @(posedge clk_i); #1;
        s_axi_awvalid_i = 1'b0;
        s_axi_wvalid_i = 1'b0;
        // full word stored whatever the strobes
        if (a == ADDR_SCRATCH) begin
            scratch_sh = d;
        end
        while (!s_axi_bvalid_o) begin
            @(posedge clk_i); #1;
        end
        repeat (stall) begin
            @(posedge clk_i); #1;
            assert (s_axi_bvalid_o) else stop_on_error("bvalid dropped before bready");
        end
        s_axi_bready_i = 1'b1;
        @(posedge clk_i); #1;
        s_axi_bready_i = 1'b0;
    endtask

    task automatic randomize_status();
        logic [31:0] r;
        r = $random(seed);
        fs_state_i = r[1:0];
        n_id_2_i = r[3:2];
        ibar_ssb_i = r[6:4];
        sample_cnt_mismatch_i = r[15:8];
        n_id_i = r[25:16];
        // keep the cell identity inside its legal range
        if (n_id_i > 10'd1007) begin
            n_id_i = n_id_i - 10'd100;
        end
        rx_signal_i = $random(seed);
        n_id_used_i = $random(seed);
    endtask

    // one-cycle pulse on sync_lost_i when lost is set, else on ssb_strobe_i
    task automatic pulse_input(input logic lost);
        if (lost) begin
            sync_lost_i = 1'b1;
        end else begin
            ssb_strobe_i = 1'b1;
        end
        @(posedge clk_i); #1;
        ssb_strobe_i = 1'b0;
        sync_lost_i = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        int d;
        logic [15:0] base;
        reset_ni = 1'b0;
        {s_axi_awvalid_i, s_axi_wvalid_i, s_axi_bready_i} = '0;
        {s_axi_arvalid_i, s_axi_rready_i, ssb_strobe_i, sync_lost_i} = '0;
        s_axi_awaddr_i = '0;
        s_axi_araddr_i = '0;
        s_axi_wdata_i = '0;
        s_axi_wstrb_i = '0;
        scratch_sh = '0;
        randomize_status();
        repeat (5) @(posedge clk_i);
        #1 reset_ni = 1'b1;

        // identification words and unmapped space
        for (int a = 0; a <= 14; a++) begin
            axil_read(9'(a), 0);
        end
        repeat (6) begin
            r = $random(seed);
            axil_read(9'h00F + {1'b0, r[7:0]}, r[10:8]);
        end

        // status inputs
        repeat (4) begin
            randomize_status();
            axil_read(ADDR_FS_STATE, 0);
            axil_read(ADDR_RX_SIGNAL, 0);
            axil_read(ADDR_N_ID_2, 0);
            axil_read(ADDR_N_ID, 0);
            axil_read(ADDR_SAMPLE_MISMATCH, 0);
            axil_read(ADDR_IBAR_SSB, 0);
            axil_read(ADDR_N_ID_USED, 0);
        end

        // scratch and read-only writes
        repeat (5) begin
            r = $random(seed);
            axil_write(ADDR_SCRATCH, $random(seed), r[3:0], r[6:4]);
            axil_read(ADDR_SCRATCH, r[9:7]);
            r = $random(seed);
            axil_write(ADDR_VERSION + {5'd0, r[3:0]}, $random(seed), 4'hF, 0);
            axil_read(ADDR_SCRATCH, 0);
            axil_read(ADDR_VERSION + {5'd0, r[3:0]}, 0);
        end

        // ssb spacing below the timeout
        repeat (6) begin
            r = $random(seed);
            d = 2 + int'(r[5:0] % 6'd60);
            pulse_input(1'b0);
            repeat (d - 1) @(posedge clk_i);
            #1 pulse_input(1'b0);
            assert (m_clks == 32'(d)) else stop_on_error(
                $sformatf("Fail clks_btwn_ssbs model got %h expected %h", m_clks, d));
            axil_read(ADDR_CLKS_BTWN_SSBS, 0);
        end

        // silences of k timeout periods, then disconnects
        for (int k = 1; k <= 3; k++) begin
            base = m_missed;
            pulse_input(1'b0);
            repeat (k * TIMEOUT) @(posedge clk_i);
            #1;
            assert (m_missed == base + 16'(k)) else stop_on_error(
                $sformatf("Fail missed_ssbs model got %h expected %h", m_missed,
                    base + 16'(k)));
            axil_read(ADDR_MISSED_SSBS, 0);
        end
        repeat (5) begin
            pulse_input(1'b1);
            axil_read(ADDR_NUM_DISCONNECTS, 0);
        end

        // read runs while a write response is held back
        fork
            axil_write(ADDR_FILL, $random(seed), 4'h3, 30);
            begin
                repeat (6) @(posedge clk_i);
                #1 axil_read(ADDR_ID, 4);
                assert (s_axi_bvalid_o) else stop_on_error(
                    "read did not complete while the write response was held");
            end
        join
        axil_read(ADDR_SCRATCH, 7);

        repeat (3) @(posedge clk_i);
        if (exp_q.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_on_error("read expectations left without a response");
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/axi_lite_pkg.sv
logic/rx_regmap_pkg.sv
logic/reg_bus_if.sv
logic/axi_lite_slave.sv
logic/ssb_monitor.sv
logic/receiver_regmap.sv
logic/rx_status_top.sv
bench/rx_status_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator; exit status follows the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module rx_status_tb -f vlog.f -o rx_status_sim &&
./obj_dir/rx_status_sim | tee /dev/stderr | grep -q "TEST PASS" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
